// ==== source/cpuPkg.sv ====
package cpuPkg;

	typedef logic [15:0] word_t;
	typedef logic [3:0] regAddr_t;

	// Values follow the instruction encoding
	typedef enum logic [3:0] {
		opAdd,
		opSub,
		opRed,
		opXor,
		opSll,
		opSra,
		opRor,
		opPaddsb,
		opLw,
		opSw,
		opLhb,
		opLlb,
		opB,
		opBr,
		opPcs,
		opHlt
	} opcode_t;

	typedef struct packed {
		logic zero;
		logic overflow;
		logic negative;
	} aluFlags_t;

	typedef struct packed {
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic regWrite;
		logic aluImm;
		logic pcs;
		logic llb;
		logic lhb;
		logic branchImm;
		logic branchReg;
		logic halt;
		logic setAllFlags;
		logic setZeroFlag;
	} control_t;

	// One register write per executed instruction
	typedef struct packed {
		logic valid;
		regAddr_t addr;
		word_t data;
		word_t pc;
	} trace_t;

	typedef enum logic [1:0] {
		stateIdle,
		stateRunning,
		stateHalted
	} runState_t;

endpackage

// ==== source/controlUnit.sv ====
module controlUnit (
	input cpuPkg::opcode_t opcode,
	output cpuPkg::control_t control
);
	import cpuPkg::*;

	localparam logic asserted = 1'b1;
	localparam logic notAsserted = 1'b0;

	always_comb begin
		control = '0;
		case (opcode)
			opAdd: begin
				control.regWrite = asserted;
			end
			opSub: begin
				control.regWrite = asserted;
			end
			opRed: begin
				control.regWrite = asserted;
			end
			opXor: begin
				control.regWrite = asserted;
			end
			// Shifts take their amount from imm4
			opSll: begin
				control.regWrite = asserted;
				control.aluImm = asserted;
			end
			opSra: begin
				control.regWrite = asserted;
				control.aluImm = asserted;
			end
			opRor: begin
				control.regWrite = asserted;
				control.aluImm = asserted;
			end
			opPaddsb: begin
				control.regWrite = asserted;
			end
			opLw: begin
				control.memRead = asserted;
				control.memToReg = asserted;
				control.regWrite = asserted;
			end
			opSw: begin
				control.memWrite = asserted;
				control.regWrite = notAsserted;
			end
			opLhb: begin
				control.regWrite = asserted;
				control.aluImm = asserted;
			end
			opLlb: begin
				control.regWrite = asserted;
				control.aluImm = asserted;
			end
			opB: begin
				control.regWrite = notAsserted;
			end
			opBr: begin
				control.regWrite = notAsserted;
			end
			opPcs: begin
				control.regWrite = asserted;
			end
			opHlt: begin
				control.regWrite = notAsserted;
			end
			default: begin
				control.regWrite = notAsserted;
			end
		endcase

		// Strobes straight from the opcode
		control.branchImm = (opcode == opB);
		control.branchReg = (opcode == opBr);
		control.lhb = (opcode == opLhb);
		control.llb = (opcode == opLlb);
		control.pcs = (opcode == opPcs);
		control.halt = (opcode == opHlt);
		control.setAllFlags = (opcode == opAdd) || (opcode == opSub);
		control.setZeroFlag = (opcode == opXor) || (opcode == opSll) ||
			(opcode == opSra) || (opcode == opRor);
	end

endmodule

// ==== source/fetchUnit.sv ====
module fetchUnit (
	input logic clk,
	input logic reset,
	input logic runReq,
	output logic runAck,
	input cpuPkg::control_t control,
	input cpuPkg::aluFlags_t flags,
	input logic [2:0] condition,
	input logic [8:0] imm9,
	input cpuPkg::word_t branchTarget,
	output cpuPkg::word_t pc,
	output logic running
);
	import cpuPkg::*;

	runState_t state;
	logic taken;
	word_t pcPlusOne;
	word_t pcImm;
	word_t pcNext;

	// Branch condition against the stored flags
	always_comb begin
		case (condition)
			3'd0: taken = !flags.zero;
			3'd1: taken = flags.zero;
			3'd2: taken = !flags.zero && !flags.negative;
			3'd3: taken = flags.negative;
			3'd4: taken = flags.zero || (!flags.zero && !flags.negative);
			3'd5: taken = flags.negative || flags.zero;
			3'd6: taken = flags.overflow;
			default: taken = 1'b1;
		endcase
	end

	always_comb begin
		pcPlusOne = pc + 16'd1;
		pcImm = pcPlusOne + {{7{imm9[8]}}, imm9};
		pcNext = pcPlusOne;
		if (control.halt)
			pcNext = pc;
		else if (control.branchImm && taken)
			pcNext = pcImm;
		else if (control.branchReg && taken)
			pcNext = branchTarget;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stateIdle;
			pc <= '0;
		end else begin
			case (state)
				stateIdle: begin
					if (runReq) begin
						state <= stateRunning;
						pc <= '0;
					end
				end
				stateRunning: begin
					pc <= pcNext;
					if (control.halt)
						state <= stateHalted;
				end
				// Hold the ack until the request is withdrawn
				stateHalted: begin
					if (!runReq)
						state <= stateIdle;
				end
				default: state <= stateIdle;
			endcase
		end
	end

	assign running = (state == stateRunning);
	assign runAck = (state == stateHalted);

endmodule

// ==== source/instructionMemory.sv ====
module instructionMemory #(
	parameter int imemDepth = 256
) (
	input logic clk,
	input logic write,
	input cpuPkg::word_t writeAddr,
	input cpuPkg::word_t writeData,
	input cpuPkg::word_t readAddr,
	output cpuPkg::word_t instr
);
	import cpuPkg::*;

	localparam int addrBits = $clog2(imemDepth);

	word_t mem [imemDepth];

	// Addresses wrap on the memory depth
	always_ff @(posedge clk) begin
		if (write)
			mem[writeAddr[addrBits-1:0]] <= writeData;
	end

	assign instr = mem[readAddr[addrBits-1:0]];

endmodule

// ==== source/registerFile.sv ====
module registerFile (
	input logic clk,
	input logic reset,
	input logic write,
	input cpuPkg::regAddr_t writeAddr,
	input cpuPkg::word_t writeData,
	input cpuPkg::regAddr_t readAddrA,
	input cpuPkg::regAddr_t readAddrB,
	output cpuPkg::word_t readDataA,
	output cpuPkg::word_t readDataB
);
	import cpuPkg::*;

	word_t regs [16];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (write && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Register 0 is hardwired
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== source/alu.sv ====
module alu (
	input logic clk,
	input logic reset,
	input logic enable,
	input cpuPkg::opcode_t opcode,
	input cpuPkg::control_t control,
	input cpuPkg::word_t a,
	input cpuPkg::word_t b,
	input logic [7:0] imm8,
	input logic [3:0] imm4,
	output cpuPkg::word_t result,
	output cpuPkg::aluFlags_t flags
);
	import cpuPkg::*;

	word_t sum;
	word_t diff;
	word_t opResult;
	word_t address;
	word_t byteMerge;
	logic [31:0] rotWide;
	logic [9:0] byteSum;
	logic [3:0] shamt;
	logic sumOvf;
	logic diffOvf;
	logic zeroNext;
	logic ovfNext;
	logic negNext;

	// Signed 4-bit add, clamped to -8..7
	function automatic logic [3:0] satAdd4(input logic [3:0] x, input logic [3:0] y);
		logic [3:0] s;
		s = x + y;
		if ((x[3] == y[3]) && (s[3] != x[3]))
			satAdd4 = x[3] ? 4'b1000 : 4'b0111;
		else
			satAdd4 = s;
	endfunction

	always_comb begin
		shamt = control.aluImm ? imm4 : b[3:0];
		sum = a + b;
		diff = a - b;
		sumOvf = (a[15] == b[15]) && (sum[15] != a[15]);
		diffOvf = (a[15] != b[15]) && (diff[15] != a[15]);
		byteSum = a[7:0] + a[15:8] + b[7:0] + b[15:8];
		rotWide = {a, a} >> shamt;
		address = a + {{12{imm4[3]}}, imm4};
		// b carries rd for the byte loads
		byteMerge = control.llb ? {b[15:8], imm8} : {imm8, b[7:0]};

		case (opcode)
			opAdd: opResult = sum;
			opSub: opResult = diff;
			opRed: opResult = {6'b0, byteSum};
			opXor: opResult = a ^ b;
			opSll: opResult = a << shamt;
			opSra: opResult = $signed(a) >>> shamt;
			opRor: opResult = rotWide[15:0];
			opPaddsb: opResult = {satAdd4(a[15:12], b[15:12]), satAdd4(a[11:8], b[11:8]),
				satAdd4(a[7:4], b[7:4]), satAdd4(a[3:0], b[3:0])};
			opLhb: opResult = byteMerge;
			opLlb: opResult = byteMerge;
			default: opResult = '0;
		endcase

		result = (control.memRead || control.memWrite) ? address : opResult;

		zeroNext = (opResult == '0);
		negNext = opResult[15];
		ovfNext = (opcode == opSub) ? diffOvf : sumOvf;
	end

	// Flags start clear on every run
	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (!enable) begin
			flags <= '0;
		end else if (control.setAllFlags) begin
			flags <= '{zero: zeroNext, overflow: ovfNext, negative: negNext};
		end else if (control.setZeroFlag) begin
			flags.zero <= zeroNext;
		end
	end

endmodule

// ==== source/memoryStage.sv ====
module memoryStage #(
	parameter int dmemDepth = 256
) (
	input logic clk,
	input logic enable,
	input cpuPkg::control_t control,
	input cpuPkg::word_t address,
	input cpuPkg::word_t storeData,
	input cpuPkg::word_t aluResult,
	input cpuPkg::word_t pcNext,
	output cpuPkg::word_t writeBack
);
	import cpuPkg::*;

	localparam int addrBits = $clog2(dmemDepth);

	word_t mem [dmemDepth];
	word_t loadData;

	always_ff @(posedge clk) begin
		if (enable && control.memWrite)
			mem[address[addrBits-1:0]] <= storeData;
	end

	assign loadData = mem[address[addrBits-1:0]];

	// Write-back source
	always_comb begin
		if (control.memToReg)
			writeBack = loadData;
		else if (control.pcs)
			writeBack = pcNext;
		else
			writeBack = aluResult;
	end

endmodule

// ==== source/cpuTop.sv ====
module cpuTop #(
	parameter int imemDepth = 256,
	parameter int dmemDepth = 256
) (
	input logic clk,
	input logic reset,
	input logic imemWrite,
	input cpuPkg::word_t imemAddr,
	input cpuPkg::word_t imemData,
	input logic runReq,
	output logic runAck,
	output cpuPkg::trace_t trace
);
	import cpuPkg::*;

	word_t instr;
	word_t pc;
	word_t pcPlusOne;
	word_t readDataA;
	word_t readDataB;
	word_t aluResult;
	word_t writeBack;
	opcode_t opcode;
	regAddr_t rd;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t readAddrB;
	logic [3:0] imm4;
	logic [7:0] imm8;
	logic [8:0] imm9;
	logic [2:0] condition;
	control_t control;
	aluFlags_t flags;
	logic running;

	assign opcode = opcode_t'(instr[15:12]);
	assign rd = instr[11:8];
	assign rs = instr[7:4];
	assign rt = instr[3:0];
	assign imm4 = instr[3:0];
	assign imm8 = instr[7:0];
	assign condition = instr[11:9];
	assign imm9 = instr[8:0];
	assign pcPlusOne = pc + 16'd1;

	// SW and the byte loads read rd on port B
	assign readAddrB = (control.memWrite || control.llb || control.lhb) ? rd : rt;

	assign trace = '{valid: running && control.regWrite, addr: rd, data: writeBack, pc: pc};

	fetchUnit fetchUnit_i (
		.clk(clk),
		.reset(reset),
		.runReq(runReq),
		.runAck(runAck),
		.control(control),
		.flags(flags),
		.condition(condition),
		.imm9(imm9),
		.branchTarget(readDataA),
		.pc(pc),
		.running(running)
	);

	// Loads only land while idle
	instructionMemory #(.imemDepth(imemDepth)) instructionMemory_i (
		.clk(clk),
		.write(imemWrite && !running && !runAck),
		.writeAddr(imemAddr),
		.writeData(imemData),
		.readAddr(pc),
		.instr(instr)
	);

	controlUnit controlUnit_i (
		.opcode(opcode),
		.control(control)
	);

	registerFile registerFile_i (
		.clk(clk),
		.reset(reset),
		.write(running && control.regWrite),
		.writeAddr(rd),
		.writeData(writeBack),
		.readAddrA(rs),
		.readAddrB(readAddrB),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	alu alu_i (
		.clk(clk),
		.reset(reset),
		.enable(running),
		.opcode(opcode),
		.control(control),
		.a(readDataA),
		.b(readDataB),
		.imm8(imm8),
		.imm4(imm4),
		.result(aluResult),
		.flags(flags)
	);

	memoryStage #(.dmemDepth(dmemDepth)) memoryStage_i (
		.clk(clk),
		.enable(running),
		.control(control),
		.address(aluResult),
		.storeData(readDataB),
		.aluResult(aluResult),
		.pcNext(pcPlusOne),
		.writeBack(writeBack)
	);

endmodule

// ==== test/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Architectural state of the reference model
word_t modelRegs [16];
word_t modelMem [dmemDepth];
logic modelZ;
logic modelV;
logic modelN;
trace_t expectedWrites [$];

// Signed nibble add, clamped to the 4-bit range
function automatic logic [3:0] satNibble(input logic [3:0] x, input logic [3:0] y);
	int s;
	s = int'($signed(x)) + int'($signed(y));
	if (s > 7)
		s = 7;
	else if (s < -8)
		s = -8;
	return 4'(s);
endfunction

// Compare outcomes from the flags, then the eight conditions built on them
function automatic logic condHolds(input logic [2:0] cond);
	logic eq;
	logic lt;
	logic gt;
	eq = modelZ;
	lt = modelN;
	gt = !modelZ && !modelN;
	case (cond)
		3'd0: return !eq;
		3'd1: return eq;
		3'd2: return gt;
		3'd3: return lt;
		3'd4: return gt || eq;
		3'd5: return lt || eq;
		3'd6: return modelV;
		default: return 1'b1;
	endcase
endfunction

// Runs prog from address 0 and queues every register write
function automatic int execProgram(input int maxSteps);
	word_t pc;
	word_t nextPc;
	word_t instr;
	word_t a;
	word_t b;
	word_t res;
	word_t addr;
	opcode_t op;
	regAddr_t rd;
	logic [3:0] sh;
	trace_t entry;
	logic writes;
	int s;
	int steps;
	pc = '0;
	steps = 0;
	modelZ = 1'b0;
	modelV = 1'b0;
	modelN = 1'b0;
	while (steps < maxSteps) begin
		instr = prog[pc % imemDepth];
		op = opcode_t'(instr[15:12]);
		rd = instr[11:8];
		sh = instr[3:0];
		a = modelRegs[instr[7:4]];
		b = modelRegs[instr[3:0]];
		addr = a + {{12{instr[3]}}, instr[3:0]};
		nextPc = pc + 16'd1;
		writes = 1'b1;
		res = '0;
		steps++;
		case (op)
			opAdd, opSub: begin
				if (op == opAdd)
					s = int'($signed(a)) + int'($signed(b));
				else
					s = int'($signed(a)) - int'($signed(b));
				res = word_t'(s);
				modelV = (s > 32767) || (s < -32768);
				modelZ = (res == 0);
				modelN = res[15];
			end
			opRed: res = a[7:0] + a[15:8] + b[7:0] + b[15:8];
			opXor: begin
				res = a ^ b;
				modelZ = (res == 0);
			end
			opSll: begin
				res = a << sh;
				modelZ = (res == 0);
			end
			opSra: begin
				res = a >> sh;
				if (a[15])
					res = res | ~(16'hFFFF >> sh);
				modelZ = (res == 0);
			end
			opRor: begin
				res = (sh == 0) ? a : ((a >> sh) | (a << (16 - sh)));
				modelZ = (res == 0);
			end
			opPaddsb: begin
				for (int i = 0; i < 4; i++)
					res[i*4 +: 4] = satNibble(a[i*4 +: 4], b[i*4 +: 4]);
			end
			opLw: res = modelMem[addr % dmemDepth];
			opSw: begin
				modelMem[addr % dmemDepth] = modelRegs[rd];
				writes = 1'b0;
			end
			opLhb: res = {instr[7:0], modelRegs[rd][7:0]};
			opLlb: res = {modelRegs[rd][15:8], instr[7:0]};
			opB: begin
				writes = 1'b0;
				if (condHolds(instr[11:9]))
					nextPc = pc + 16'd1 + {{7{instr[8]}}, instr[8:0]};
			end
			opBr: begin
				writes = 1'b0;
				if (condHolds(instr[11:9]))
					nextPc = a;
			end
			opPcs: res = pc + 16'd1;
			default: return steps;
		endcase
		if (writes) begin
			entry.valid = 1'b1;
			entry.addr = rd;
			entry.data = res;
			entry.pc = pc;
			expectedWrites.push_back(entry);
			if (rd != 0)
				modelRegs[rd] = res;
		end
		pc = nextPc;
	end
	return steps;
endfunction

`endif

// ==== test/cpuTb.sv ====
module cpuTb;
	timeunit 1ns;
	timeprecision 1ps;

	import cpuPkg::*;

	localparam int imemDepth = 256;
	localparam int dmemDepth = 256;
	// Instruction counts of the seven programs
	localparam int progTotal = 1 + 79 + 52 + 49 + 145 + 3 + 5;
	localparam int runCount = 7;
	localparam int runOverhead = 20;
	localparam int watchdogCycles = (progTotal + runCount * runOverhead) * 20;

	logic clk;
	logic reset;
	logic imemWrite;
	word_t imemAddr;
	word_t imemData;
	logic runReq;
	logic runAck;
	trace_t trace;

	word_t prog [imemDepth];
	int progLen;
	logic [15:0] lfsrState;
	string testName;
	int errors;
	int checks;

	`include "isaModel.svh"

	cpuTop #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) dut_i (
		.clk(clk),
		.reset(reset),
		.imemWrite(imemWrite),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.runReq(runReq),
		.runAck(runAck),
		.trace(trace)
	);

	always #5 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] randomBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[14:0], lfsrState[0]};
		end
		return v;
	endfunction

	function automatic word_t encodeReg(input opcode_t op, input regAddr_t rd,
		input regAddr_t rs, input logic [3:0] low);
		return {op, rd, rs, low};
	endfunction

	function automatic word_t encodeImm(input opcode_t op, input regAddr_t rd,
		input logic [7:0] imm8);
		return {op, rd, imm8};
	endfunction

	function automatic word_t encodeBranch(input logic [2:0] cond, input logic [8:0] imm9);
		return {opB, cond, imm9};
	endfunction

	function automatic word_t encodeBr(input logic [2:0] cond, input regAddr_t rs);
		return {opBr, cond, 1'b0, rs, 4'b0};
	endfunction

	function automatic void emit(input word_t w);
		prog[progLen] = w;
		progLen++;
	endfunction

	function automatic void emitFlagOp();
		opcode_t op;
		regAddr_t rs;
		regAddr_t rt;
		op = (randomBits(2) % 3 == 0) ? opXor : (randomBits(1) ? opAdd : opSub);
		rs = 4'(randomBits(4));
		// Equal operands give a zero result
		rt = randomBits(1) ? rs : 4'(randomBits(4));
		emit(encodeReg(op, 4'(1 + randomBits(4) % 12), rs, rt));
	endfunction

	task automatic loadProgram();
		for (int i = 0; i < progLen; i++) begin
			@(posedge clk);
			#1;
			imemWrite = 1'b1;
			imemAddr = word_t'(i);
			imemData = prog[i];
		end
		@(posedge clk);
		#1;
		imemWrite = 1'b0;
	endtask

	// Load, full four-phase handshake, then check ack timing
	task automatic runProgram();
		int steps;
		int cycles;
		int limit;
		loadProgram();
		steps = execProgram(4 * progLen + 16);
		limit = steps + runOverhead;
		@(posedge clk);
		#1;
		runReq = 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (!runAck && cycles < limit);
		checks++;
		if (!runAck) begin
			errors++;
			$display("%s: runAck did not rise within %0d cycles", testName, limit);
		end else if (cycles != steps + 1) begin
			errors++;
			$display("[ERROR] %s: runAck cycle expected %0d actual %0d",
				testName, steps + 1, cycles);
		end
		checks++;
		if (expectedWrites.size() != 0) begin
			errors++;
			$display("%s: %0d expected register writes never appeared",
				testName, expectedWrites.size());
			expectedWrites.delete();
		end
		runReq = 1'b0;
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (runAck && cycles < runOverhead);
		checks++;
		if (runAck) begin
			errors++;
			$display("%s: runAck stayed high after runReq fell", testName);
		end else if (cycles != 1) begin
			errors++;
			$display("[ERROR] %s: runAck fall cycle expected 1 actual %0d", testName, cycles);
		end
	endtask

	task automatic buildAluProgram();
		opcode_t aluOps [5];
		aluOps = '{opAdd, opSub, opRed, opXor, opPaddsb};
		progLen = 0;
		for (int r = 1; r < 16; r++) begin
			emit(encodeImm(opLlb, 4'(r), 8'(randomBits(8))));
			emit(encodeImm(opLhb, 4'(r), 8'(randomBits(8))));
		end
		// Signed overflow and nibble saturation corners
		emit(encodeImm(opLlb, 4'd1, 8'h77));
		emit(encodeImm(opLhb, 4'd1, 8'h7F));
		emit(encodeImm(opLlb, 4'd2, 8'h88));
		emit(encodeImm(opLhb, 4'd2, 8'h80));
		emit(encodeReg(opAdd, 4'd3, 4'd1, 4'd1));
		emit(encodeReg(opSub, 4'd4, 4'd2, 4'd1));
		emit(encodeReg(opPaddsb, 4'd5, 4'd1, 4'd1));
		emit(encodeReg(opPaddsb, 4'd6, 4'd2, 4'd2));
		for (int i = 0; i < 40; i++)
			emit(encodeReg(aluOps[randomBits(3) % 5], 4'(randomBits(4)),
				4'(randomBits(4)), 4'(randomBits(4))));
		emit(encodeReg(opHlt, 4'd0, 4'd0, 4'd0));
	endtask

	task automatic buildShiftProgram();
		progLen = 0;
		for (int sh = 0; sh < 16; sh++) begin
			emit(encodeReg(opSll, 4'(randomBits(4)), 4'(randomBits(4)), 4'(sh)));
			emit(encodeReg(opSra, 4'd0, 4'(randomBits(4)), 4'(sh)));
			emit(encodeReg(opRor, 4'(randomBits(4)), 4'(randomBits(4)), 4'(sh)));
		end
		// A write to r0 that is never zero
		emit(encodeImm(opLlb, 4'd0, 8'hFF));
		// r0 must still read as zero
		emit(encodeReg(opAdd, 4'd10, 4'd0, 4'd0));
		emit(encodeReg(opXor, 4'd11, 4'd0, 4'd12));
		emit(encodeReg(opHlt, 4'd0, 4'd0, 4'd0));
	endtask

	task automatic buildMemoryProgram();
		regAddr_t base;
		logic [3:0] offset;
		progLen = 0;
		for (int i = 0; i < 24; i++) begin
			base = 4'(randomBits(4));
			offset = 4'(randomBits(4));
			emit(encodeReg(opSw, 4'(randomBits(4)), base, offset));
			emit(encodeReg(opLw, 4'(randomBits(4)), base, offset));
		end
		emit(encodeReg(opHlt, 4'd0, 4'd0, 4'd0));
	endtask

	task automatic buildBranchProgram();
		word_t target;
		progLen = 0;
		for (int round = 0; round < 2; round++) begin
			for (int cond = 0; cond < 8; cond++) begin
				emitFlagOp();
				emit(encodeBranch(3'(cond), 9'd1));
				emit(encodeImm(opLlb, 4'd14, 8'(randomBits(8))));
				emitFlagOp();
				// Lands just past the LLB after BR
				target = word_t'(progLen + 4);
				emit(encodeImm(opLlb, 4'd13, target[7:0]));
				emit(encodeImm(opLhb, 4'd13, target[15:8]));
				emit(encodeBr(3'(cond), 4'd13));
				emit(encodeImm(opLlb, 4'd15, 8'(randomBits(8))));
				emit(encodeReg(opPcs, 4'(randomBits(4)), 4'd0, 4'd0));
			end
		end
		emit(encodeReg(opHlt, 4'd0, 4'd0, 4'd0));
	endtask

	always @(negedge clk) begin : compareTrace
		trace_t expected;
		if (!reset && trace.valid) begin
			checks++;
			if (expectedWrites.size() == 0) begin
				errors++;
				$display("%s: unexpected write to r%0d at pc %0d", testName, trace.addr, trace.pc);
			end else begin
				expected = expectedWrites.pop_front();
				if (trace.pc !== expected.pc) begin
					errors++;
					$display("[ERROR] %s: pc expected %0d actual %0d",
						testName, expected.pc, trace.pc);
				end
				if (trace.addr !== expected.addr) begin
					errors++;
					$display("[ERROR] %s: pc %0d addr expected %0d actual %0d",
						testName, expected.pc, expected.addr, trace.addr);
				end
				if (trace.data !== expected.data) begin
					errors++;
					$display("[ERROR] %s: pc %0d data expected %h actual %h",
						testName, expected.pc, expected.data, trace.data);
				end
			end
		end
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles in %s", watchdogCycles, testName);
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		imemWrite = 1'b0;
		imemAddr = '0;
		imemData = '0;
		runReq = 1'b0;
		lfsrState = 16'd52;
		errors = 0;
		checks = 0;
		testName = "reset";
		for (int i = 0; i < 16; i++)
			modelRegs[i] = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		testName = "haltOnly";
		checks++;
		if (runAck !== 1'b0 || trace.valid !== 1'b0) begin
			errors++;
			$display("%s: runAck or trace valid not low after reset", testName);
		end
		progLen = 0;
		emit(encodeReg(opHlt, 4'd0, 4'd0, 4'd0));
		runProgram();

		testName = "aluOps";
		buildAluProgram();
		runProgram();

		testName = "shifts";
		buildShiftProgram();
		runProgram();

		testName = "loadStore";
		buildMemoryProgram();
		runProgram();

		testName = "branches";
		buildBranchProgram();
		runProgram();

		testName = "backToBack";
		progLen = 0;
		emit(encodeReg(opSub, 4'd1, 4'd2, 4'd2));
		emit(encodeImm(opLlb, 4'd9, 8'h5A));
		emit(encodeReg(opHlt, 4'd0, 4'd0, 4'd0));
		runProgram();
		progLen = 0;
		// Z starts clear, so this falls through
		emit(encodeBranch(3'd1, 9'd1));
		emit(encodeImm(opLlb, 4'd9, 8'hA5));
		emit(encodeReg(opPcs, 4'd10, 4'd0, 4'd0));
		emit(encodeReg(opAdd, 4'd11, 4'd9, 4'd2));
		emit(encodeReg(opHlt, 4'd0, 4'd0, 4'd0));
		runProgram();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+test
source/cpuPkg.sv
source/controlUnit.sv
source/fetchUnit.sv
source/instructionMemory.sv
source/registerFile.sv
source/alu.sv
source/memoryStage.sv
source/cpuTop.sv
test/cpuTb.sv
